//--- design/mem_map_pkg.sv
// ----------------------------------------
// memory map package: address map, widths,
// status magic values and interrupt ids
// ----------------------------------------
package mem_map_pkg;

    // bus and RAM widths
    localparam int ADDR_WIDTH        = 32;
    localparam int RAM_ADDR_WIDTH    = 16;
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int INSTR_LINE_BYTES  = INSTR_RDATA_WIDTH / 8;
    localparam int DATA_WIDTH        = 32;
    localparam int BE_WIDTH          = 4;
    localparam int IRQ_ID_WIDTH      = 5;

    // pseudo peripheral addresses
    localparam logic [ADDR_WIDTH-1:0] ADDR_TEST_STATUS = 32'h2000_0000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TEST_EXIT   = 32'h2000_0004;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TIMER_MASK  = 32'h1500_0000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TIMER_COUNT = 32'h1500_0004;
    localparam logic [ADDR_WIDTH-1:0] ADDR_DEBUG_CTRL  = 32'h1500_0008;

    // values written by the test program
    localparam logic [DATA_WIDTH-1:0] TEST_PASS_VALUE = 32'd123456789;
    localparam logic [DATA_WIDTH-1:0] TEST_FAIL_VALUE = 32'd1;

    localparam int TIMER_IRQ_ID = 3;

    // debug generator counter widths and the stand-in for a zero count
    localparam int DEBUG_DELAY_WIDTH    = 15;
    localparam int DEBUG_DURATION_WIDTH = 13;
    localparam int DEFAULT_DEBUG_COUNT  = 1;

endpackage

//--- design/bus_pkg.sv
// ----------------------------------------
// bus package: structs for the data bus,
// the RAM port and the peripheral paths
// ----------------------------------------
package bus_pkg;

    import mem_map_pkg::*;

    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [BE_WIDTH-1:0]   be;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [DATA_WIDTH-1:0] rdata;
    } data_rsp_t;

    // word aligned request into the RAM data port
    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [BE_WIDTH-1:0]       be;
        logic [RAM_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     wdata;
    } ram_port_t;

    // one cycle write strobes, at most one set at a time
    typedef struct packed {
        logic                  timer_mask_we;
        logic                  timer_count_we;
        logic                  debug_we;
        logic [DATA_WIDTH-1:0] wdata;
    } periph_wr_t;

    typedef struct packed {
        logic                  passed;
        logic                  failed;
        logic                  exit_valid;
        logic [DATA_WIDTH-1:0] exit_value;
    } test_status_t;

    // layout of the word written to the debug control address
    typedef struct packed {
        logic                            value;
        logic                            pulse;
        logic                            rsvd_29;
        logic [DEBUG_DURATION_WIDTH-1:0] duration;
        logic                            rsvd_15;
        logic [DEBUG_DELAY_WIDTH-1:0]    delay;
    } debug_cfg_t;

endpackage

//--- design/dp_ram.sv
// ----------------------------------------
// dual port RAM with a wide fetch port and
// a byte enabled 32-bit data port
// ----------------------------------------
module dp_ram
    import mem_map_pkg::*;
    import bus_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         instr_en_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
    output logic                         instr_rvalid_o,
    input  ram_port_t                    data_port_i,
    output logic [DATA_WIDTH-1:0]        data_rdata_o
);

    logic [7:0]                mem [2**RAM_ADDR_WIDTH];
    logic [RAM_ADDR_WIDTH-1:0] instr_base;

    // fetch lines start on a 16 byte boundary
    assign instr_base = instr_addr_i & ~RAM_ADDR_WIDTH'(INSTR_LINE_BYTES - 1);

    always_ff @(posedge clk_i) begin : instr_read
        if (instr_en_i) begin
            for (int i = 0; i < INSTR_LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + RAM_ADDR_WIDTH'(i)];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : instr_valid
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_en_i;
        end
    end

    // read returns the old word when a write hits the same address
    always_ff @(posedge clk_i) begin : data_access
        if (data_port_i.en) begin
            for (int i = 0; i < BE_WIDTH; i++) begin
                if (data_port_i.we && data_port_i.be[i]) begin
                    mem[data_port_i.addr + RAM_ADDR_WIDTH'(i)] <= data_port_i.wdata[8*i +: 8];
                end
                data_rdata_o[8*i +: 8] <= mem[data_port_i.addr + RAM_ADDR_WIDTH'(i)];
            end
        end
    end

endmodule

//--- design/data_decoder.sv
// ----------------------------------------
// data bus address decoder for the RAM and
// the pseudo peripherals
// ----------------------------------------
module data_decoder
    import mem_map_pkg::*;
    import bus_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  data_req_t    data_req_i,
    output ram_port_t    ram_port_o,
    output periph_wr_t   periph_wr_o,
    output test_status_t status_o,
    output logic         rsel_ram_o
);

    logic in_ram;
    logic wr;
    logic hit_status;
    logic hit_exit;
    logic hit_mask;
    logic hit_count;
    logic hit_debug;

    assign in_ram = data_req_i.addr[ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0;
    assign wr     = data_req_i.req && data_req_i.we;

    assign hit_status = data_req_i.addr == ADDR_TEST_STATUS;
    assign hit_exit   = data_req_i.addr == ADDR_TEST_EXIT;
    assign hit_mask   = data_req_i.addr == ADDR_TIMER_MASK;
    assign hit_count  = data_req_i.addr == ADDR_TIMER_COUNT;
    assign hit_debug  = data_req_i.addr == ADDR_DEBUG_CTRL;

    // ----------------------------------------
    // RAM port
    always_comb begin
        ram_port_o.en    = data_req_i.req && in_ram;
        ram_port_o.we    = data_req_i.we;
        ram_port_o.be    = data_req_i.be;
        ram_port_o.addr  = data_req_i.addr[RAM_ADDR_WIDTH-1:0]
                           & ~RAM_ADDR_WIDTH'(BE_WIDTH - 1);
        ram_port_o.wdata = data_req_i.wdata;
    end

    // only RAM reads return data, everything else reads as zero
    assign rsel_ram_o = data_req_i.req && !data_req_i.we && in_ram;

    // ----------------------------------------
    // peripheral strobes and test status
    always_comb begin
        periph_wr_o.timer_mask_we  = wr && hit_mask;
        periph_wr_o.timer_count_we = wr && hit_count;
        periph_wr_o.debug_we       = wr && hit_debug;
        periph_wr_o.wdata          = data_req_i.wdata;

        status_o.passed     = wr && hit_status && data_req_i.wdata == TEST_PASS_VALUE;
        status_o.failed     = wr && hit_status && data_req_i.wdata == TEST_FAIL_VALUE;
        status_o.exit_valid = wr && hit_exit;
        status_o.exit_value = (wr && hit_exit) ? data_req_i.wdata : '0;
    end

    unmapped_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wr |-> (in_ram || hit_status || hit_exit || hit_mask || hit_count || hit_debug))
        else $error("write to unmapped address %08h", data_req_i.addr);

endmodule

//--- design/data_resp_ctrl.sv
// ----------------------------------------
// data response path: grant, read valid
// and read data select
// ----------------------------------------
module data_resp_ctrl
    import mem_map_pkg::*;
    import bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_i,
    input  logic                  rsel_ram_i,
    input  logic [DATA_WIDTH-1:0] ram_rdata_i,
    output data_rsp_t             data_rsp_o
);

    logic rvalid_q;
    logic rsel_ram_q;

    // every request completes one cycle later, no wait states
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q   <= 1'b0;
            rsel_ram_q <= 1'b0;
        end else begin
            rvalid_q   <= req_i;
            rsel_ram_q <= rsel_ram_i;
        end
    end

    always_comb begin
        data_rsp_o.gnt    = req_i;
        data_rsp_o.rvalid = rvalid_q;
        // writes and unmapped reads return zero
        data_rsp_o.rdata  = rsel_ram_q ? ram_rdata_i : '0;
    end

    rvalid_follows_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        data_rsp_o.rvalid |-> $past(req_i))
        else $error("rvalid without a request in the previous cycle");

endmodule

//--- design/timer_irq.sv
// ----------------------------------------
// countdown timer raising the timer irq
// ----------------------------------------
module timer_irq
    import mem_map_pkg::*;
    import bus_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  periph_wr_t              periph_wr_i,
    input  logic                    irq_ack_i,
    input  logic [IRQ_ID_WIDTH-1:0] irq_ack_id_i,
    output logic                    irq_o
);

    logic                  irq_en_q;
    logic [DATA_WIDTH-1:0] count_q;
    logic                  ack_hit;

    assign ack_hit = irq_ack_i && irq_ack_id_i == IRQ_ID_WIDTH'(TIMER_IRQ_ID);

    // a mask or count write takes the place of the countdown step
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_en_q <= 1'b0;
            count_q  <= '0;
            irq_o    <= 1'b0;
        end else begin
            if (periph_wr_i.timer_mask_we) begin
                irq_en_q <= periph_wr_i.wdata[TIMER_IRQ_ID];
            end else if (periph_wr_i.timer_count_we) begin
                count_q <= periph_wr_i.wdata;
            end else if (count_q != '0) begin
                count_q <= count_q - 1'b1;
                // irq on the step from 1 to 0
                if (count_q == DATA_WIDTH'(1) && irq_en_q) begin
                    irq_o <= 1'b1;
                end
            end
            if (ack_hit) begin
                irq_o <= 1'b0;
            end
        end
    end

endmodule

//--- design/debug_req_gen.sv
// ----------------------------------------
// debug request generator with start delay
// and optional pulse duration
// ----------------------------------------
module debug_req_gen
    import mem_map_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  periph_wr_t periph_wr_i,
    output logic       debug_req_o
);

    debug_cfg_t                      cfg;
    logic                            accept;
    logic [DEBUG_DELAY_WIDTH-1:0]    start_cnt_q;
    logic [DEBUG_DURATION_WIDTH-1:0] dur_cnt_q;
    logic [DEBUG_DURATION_WIDTH-1:0] dur_len_q;
    logic                            value_q;
    logic                            pulse_q;

    assign cfg = debug_cfg_t'(periph_wr_i.wdata);

    // new configs only while both counters sit idle
    assign accept = periph_wr_i.debug_we && start_cnt_q == '0 && dur_cnt_q == '0;

    // ----------------------------------------
    // captured configuration
    always_ff @(posedge clk_i) begin
        if (accept) begin
            value_q   <= cfg.value;
            pulse_q   <= cfg.pulse;
            dur_len_q <= (cfg.duration == '0) ?
                         DEBUG_DURATION_WIDTH'(DEFAULT_DEBUG_COUNT) : cfg.duration;
        end
    end

    // ----------------------------------------
    // start delay then pulse duration
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_cnt_q <= '0;
            dur_cnt_q   <= '0;
            debug_req_o <= 1'b0;
        end else if (accept) begin
            start_cnt_q <= (cfg.delay == '0) ?
                           DEBUG_DELAY_WIDTH'(DEFAULT_DEBUG_COUNT) : cfg.delay;
        end else if (start_cnt_q != '0) begin
            start_cnt_q <= start_cnt_q - 1'b1;
            if (start_cnt_q == DEBUG_DELAY_WIDTH'(1)) begin
                debug_req_o <= value_q;
                // level mode leaves the duration counter at zero
                dur_cnt_q   <= pulse_q ? dur_len_q : '0;
            end
        end else if (dur_cnt_q != '0) begin
            dur_cnt_q <= dur_cnt_q - 1'b1;
            if (dur_cnt_q == DEBUG_DURATION_WIDTH'(1)) begin
                debug_req_o <= !value_q;
            end
        end
    end

    counters_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(start_cnt_q != '0 && dur_cnt_q != '0))
        else $error("start and duration counters both running");

endmodule

//--- design/mm_ram.sv
// ----------------------------------------
// memory and pseudo peripheral model for a
// RISC-V core in simulation
// ----------------------------------------
module mm_ram
    import mem_map_pkg::*;
    import bus_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_ni,

    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  data_req_t                    data_req_i,
    output data_rsp_t                    data_rsp_o,

    input  logic                         irq_ack_i,
    input  logic [IRQ_ID_WIDTH-1:0]      irq_ack_id_i,
    output logic                         irq_o,
    output logic                         debug_req_o,
    output test_status_t                 status_o
);

    ram_port_t             ram_port;
    periph_wr_t            periph_wr;
    logic                  rsel_ram;
    logic [DATA_WIDTH-1:0] ram_rdata;

    // fetches are always granted at once
    assign instr_gnt_o = instr_req_i;

    dp_ram dp_ram_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_en_i     (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_port_i    (ram_port),
        .data_rdata_o   (ram_rdata)
    );

    data_decoder data_decoder_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .data_req_i  (data_req_i),
        .ram_port_o  (ram_port),
        .periph_wr_o (periph_wr),
        .status_o    (status_o),
        .rsel_ram_o  (rsel_ram)
    );

    data_resp_ctrl data_resp_ctrl_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (data_req_i.req),
        .rsel_ram_i  (rsel_ram),
        .ram_rdata_i (ram_rdata),
        .data_rsp_o  (data_rsp_o)
    );

    timer_irq timer_irq_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .periph_wr_i  (periph_wr),
        .irq_ack_i    (irq_ack_i),
        .irq_ack_id_i (irq_ack_id_i),
        .irq_o        (irq_o)
    );

    debug_req_gen debug_req_gen_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .periph_wr_i (periph_wr),
        .debug_req_o (debug_req_o)
    );

endmodule

//--- test/tb_mm_ram.sv
// ----------------------------------------
// testbench for mm_ram covering the RAM
// ports, status, timer irq and debug requests
// ----------------------------------------
module tb_mm_ram
    import mem_map_pkg::*;
    import bus_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 15120;
    localparam logic [RAM_ADDR_WIDTH-1:0] RAM_BASE = 16'h0100;
    localparam int RAM_WORDS    = 64;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_FETCH    = 64;
    localparam int NUM_OPS      = RAM_WORDS + NUM_RANDOM + 2 * NUM_FETCH + 16;
    // longest timer count or debug delay plus duration in use
    localparam int MAX_DELAY    = 8;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         instr_req_i;
    logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i;
    logic                         instr_gnt_o;
    logic                         instr_rvalid_o;
    logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o;
    data_req_t                    data_req_i;
    data_rsp_t                    data_rsp_o;
    logic                         irq_ack_i;
    logic [IRQ_ID_WIDTH-1:0]      irq_ack_id_i;
    logic                         irq_o;
    logic                         debug_req_o;
    test_status_t                 status_o;

    // byte model of the RAM and the responses still owed by the DUT
    logic [7:0]                   model [2**RAM_ADDR_WIDTH];
    logic [DATA_WIDTH-1:0]        data_exp_q [$];
    logic [INSTR_RDATA_WIDTH-1:0] line_exp_q [$];
    logic                         data_gnt_q;
    logic                         instr_gnt_q;
    logic                         debug_level;
    int                           errors;
    int                           checks;

    mm_ram mm_ram_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_rsp_o     (data_rsp_o),
        .irq_ack_i      (irq_ack_i),
        .irq_ack_id_i   (irq_ack_id_i),
        .irq_o          (irq_o),
        .debug_req_o    (debug_req_o),
        .status_o       (status_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic compare(input string what, input logic [INSTR_RDATA_WIDTH-1:0] got,
                           input logic [INSTR_RDATA_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // ----------------------------------------
    // reference model
    function automatic void model_write(input logic [RAM_ADDR_WIDTH-1:0] addr,
                                        input logic [BE_WIDTH-1:0] be,
                                        input logic [DATA_WIDTH-1:0] wdata);
        logic [RAM_ADDR_WIDTH-1:0] base;
        base = addr & ~RAM_ADDR_WIDTH'(BE_WIDTH - 1);
        for (int i = 0; i < BE_WIDTH; i++) begin
            if (be[i]) begin
                model[base + RAM_ADDR_WIDTH'(i)] = wdata[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expect_word(input logic [RAM_ADDR_WIDTH-1:0] addr);
        logic [RAM_ADDR_WIDTH-1:0] base;
        logic [DATA_WIDTH-1:0]     word;
        base = addr & ~RAM_ADDR_WIDTH'(BE_WIDTH - 1);
        for (int i = 0; i < BE_WIDTH; i++) begin
            word[8*i +: 8] = model[base + RAM_ADDR_WIDTH'(i)];
        end
        return word;
    endfunction

    function automatic logic [INSTR_RDATA_WIDTH-1:0] expect_line(
        input logic [RAM_ADDR_WIDTH-1:0] addr);
        logic [RAM_ADDR_WIDTH-1:0]    base;
        logic [INSTR_RDATA_WIDTH-1:0] line;
        base = addr & ~RAM_ADDR_WIDTH'(INSTR_LINE_BYTES - 1);
        for (int i = 0; i < INSTR_LINE_BYTES; i++) begin
            line[8*i +: 8] = model[base + RAM_ADDR_WIDTH'(i)];
        end
        return line;
    endfunction

    // edges counts clock edges after the one that captured the write
    function automatic logic expect_irq(input int edges, input int count, input logic masked);
        return masked && count > 0 && edges >= count;
    endfunction

    function automatic logic expect_debug(input int edges, input debug_cfg_t cfg,
                                          input logic prev);
        int d;
        int p;
        d = (cfg.delay == '0) ? DEFAULT_DEBUG_COUNT : int'(cfg.delay);
        p = (cfg.duration == '0) ? DEFAULT_DEBUG_COUNT : int'(cfg.duration);
        if (edges < d) begin
            return prev;
        end
        if (!cfg.pulse || edges < d + p) begin
            return cfg.value;
        end
        return !cfg.value;
    endfunction

    function automatic debug_cfg_t make_cfg(input logic value, input logic pulse,
                                            input int duration, input int delay);
        debug_cfg_t cfg;
        cfg.value    = value;
        cfg.pulse    = pulse;
        // ignored bits set to one to expose any decode that uses them
        cfg.rsvd_29  = 1'b1;
        cfg.duration = DEBUG_DURATION_WIDTH'(duration);
        cfg.rsvd_15  = 1'b1;
        cfg.delay    = DEBUG_DELAY_WIDTH'(delay);
        return cfg;
    endfunction

    // ----------------------------------------
    // stimulus tasks
    task automatic drive_req(input logic we, input logic [BE_WIDTH-1:0] be,
                             input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] wdata);
        @(posedge clk_i);
        #2;
        data_req_i = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
        if (addr[ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0) begin
            if (we) begin
                model_write(addr[RAM_ADDR_WIDTH-1:0], be, wdata);
            end
            data_exp_q.push_back(we ? '0 : expect_word(addr[RAM_ADDR_WIDTH-1:0]));
        end else begin
            data_exp_q.push_back('0);
        end
    endtask

    task automatic drive_idle();
        @(posedge clk_i);
        #2;
        data_req_i = '0;
    endtask

    task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] wdata);
        drive_req(1'b1, 4'hf, addr, wdata);
        drive_idle();
    endtask

    task automatic status_write(input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] wdata);
        logic is_status;
        logic is_exit;
        is_status = addr == ADDR_TEST_STATUS;
        is_exit   = addr == ADDR_TEST_EXIT;
        drive_req(1'b1, 4'hf, addr, wdata);
        @(negedge clk_i);
        compare("status passed", status_o.passed, is_status && wdata == TEST_PASS_VALUE);
        compare("status failed", status_o.failed, is_status && wdata == TEST_FAIL_VALUE);
        compare("status exit valid", status_o.exit_valid, is_exit);
        if (is_exit) begin
            compare("status exit value", status_o.exit_value, wdata);
        end
    endtask

    task automatic timer_run(input logic masked, input int count);
        write_reg(ADDR_TIMER_MASK, DATA_WIDTH'(masked) << TIMER_IRQ_ID);
        write_reg(ADDR_TIMER_COUNT, DATA_WIDTH'(count));
        for (int j = 0; j <= count + 1; j++) begin
            @(negedge clk_i);
            compare("timer irq", irq_o, expect_irq(j, count, masked));
        end
        // an acknowledge for another id leaves the irq alone
        @(posedge clk_i);
        #2;
        irq_ack_i    = 1'b1;
        irq_ack_id_i = IRQ_ID_WIDTH'(TIMER_IRQ_ID + 1);
        @(posedge clk_i);
        #2;
        irq_ack_id_i = IRQ_ID_WIDTH'(TIMER_IRQ_ID);
        @(negedge clk_i);
        compare("irq after other ack", irq_o, expect_irq(count + 3, count, masked));
        @(posedge clk_i);
        #2;
        irq_ack_i = 1'b0;
        @(negedge clk_i);
        compare("irq after ack", irq_o, 1'b0);
    endtask

    task automatic debug_run(input debug_cfg_t cfg, input logic intrude);
        int   span;
        logic prev;
        prev = debug_level;
        span = int'(cfg.delay) + int'(cfg.duration) + 3;
        write_reg(ADDR_DEBUG_CTRL, cfg);
        for (int j = 0; j <= span; j++) begin
            @(negedge clk_i);
            compare("debug req", debug_req_o, expect_debug(j, cfg, prev));
            // second config arrives while the delay is still running
            if (intrude && j == 1) begin
                drive_req(1'b1, 4'hf, ADDR_DEBUG_CTRL, make_cfg(1'b0, 1'b0, 0, 1));
            end else if (intrude && j == 2) begin
                drive_idle();
            end
        end
        debug_level = expect_debug(span, cfg, prev);
    endtask

    // ----------------------------------------
    // response checker expecting rvalid one cycle after each grant
    always @(negedge clk_i) begin : response_check
        if (rst_ni) begin
            compare("data gnt", data_rsp_o.gnt, data_req_i.req);
            compare("instr gnt", instr_gnt_o, instr_req_i);
            compare("data rvalid", data_rsp_o.rvalid, data_gnt_q);
            if (data_rsp_o.rvalid === 1'b1) begin
                if (data_exp_q.size() == 0) begin
                    errors++;
                    $display("data response arrived with no request outstanding");
                end else begin
                    compare("data rdata", data_rsp_o.rdata, data_exp_q.pop_front());
                end
            end
            compare("instr rvalid", instr_rvalid_o, instr_gnt_q);
            if (instr_rvalid_o === 1'b1) begin
                if (line_exp_q.size() == 0) begin
                    errors++;
                    $display("fetch response arrived with no fetch outstanding");
                end else begin
                    compare("instr rdata", instr_rdata_o, line_exp_q.pop_front());
                end
            end
        end
        data_gnt_q  = rst_ni && data_req_i.req;
        instr_gnt_q = rst_ni && instr_req_i;
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_OPS * (MAX_DELAY + 2)));
        $display("timeout: the test did not reach its end in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ----------------------------------------
    // main sequence
    initial begin : stimulus
        logic [RAM_ADDR_WIDTH-1:0] addr;
        void'($urandom(SEED));
        errors       = 0;
        checks       = 0;
        debug_level  = 1'b0;
        data_gnt_q   = 1'b0;
        instr_gnt_q  = 1'b0;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = '0;
        irq_ack_i    = 1'b0;
        irq_ack_id_i = '0;

        repeat (RESET_CYCLES - 1) @(posedge clk_i);
        @(negedge clk_i);
        compare("reset irq", irq_o, 1'b0);
        compare("reset debug req", debug_req_o, 1'b0);
        compare("reset instr rvalid", instr_rvalid_o, 1'b0);
        compare("reset data rvalid", data_rsp_o.rvalid, 1'b0);
        compare("reset status", status_o, '0);
        @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // fill pattern built from the full byte address
        for (int w = 0; w < RAM_WORDS; w++) begin
            addr = RAM_BASE + RAM_ADDR_WIDTH'(4 * w);
            drive_req(1'b1, 4'hf, {16'h0, addr}, {addr ^ 16'h5a5a, addr});
        end

        // random writes, reads and gaps with most requests back to back
        for (int n = 0; n < NUM_RANDOM; n++) begin
            addr = RAM_BASE + RAM_ADDR_WIDTH'($urandom_range(0, 4 * RAM_WORDS - 1));
            case ($urandom_range(0, 2))
                0: drive_req(1'b1, 4'($urandom_range(0, 15)), {16'h0, addr}, $urandom());
                1: drive_req(1'b0, 4'hf, {16'h0, addr}, '0);
                default: drive_idle();
            endcase
        end
        drive_idle();

        for (int n = 0; n < NUM_FETCH; n++) begin
            @(posedge clk_i);
            #2;
            instr_req_i  = $urandom_range(0, 3) != 0;
            instr_addr_i = RAM_BASE + RAM_ADDR_WIDTH'($urandom_range(0, 4 * RAM_WORDS - 1));
            if (instr_req_i) begin
                line_exp_q.push_back(expect_line(instr_addr_i));
            end
        end
        @(posedge clk_i);
        #2;
        instr_req_i = 1'b0;

        status_write(ADDR_TEST_STATUS, TEST_PASS_VALUE);
        status_write(ADDR_TEST_STATUS, TEST_FAIL_VALUE);
        status_write(ADDR_TEST_STATUS, 32'h0000_0042);
        status_write(ADDR_TEST_EXIT, 32'h0000_00a5);
        drive_idle();

        timer_run(1'b1, 6);
        timer_run(1'b1, 1);
        timer_run(1'b0, 4);

        debug_run(make_cfg(1'b1, 1'b0, 0, 3), 1'b0);
        debug_run(make_cfg(1'b0, 1'b1, 2, 0), 1'b0);
        debug_run(make_cfg(1'b1, 1'b1, 0, 2), 1'b0);
        debug_run(make_cfg(1'b1, 1'b0, 0, 5), 1'b1);

        // nonzero data at RAM word 0 exposes an unmapped read that aliases into the RAM
        drive_req(1'b1, 4'hf, 32'h0000_0000, 32'h1357_9bdf);

        // unmapped reads complete and return zero
        drive_req(1'b0, 4'hf, 32'h3000_0000, '0);
        drive_req(1'b0, 4'hf, 32'h0001_0000, '0);
        drive_idle();
        repeat (3) @(posedge clk_i);

        if (data_exp_q.size() != 0 || line_exp_q.size() != 0) begin
            errors++;
            $display("responses still outstanding at the end of the test");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
design/mem_map_pkg.sv
design/bus_pkg.sv
design/dp_ram.sv
design/data_decoder.sv
design/data_resp_ctrl.sv
design/timer_irq.sv
design/debug_req_gen.sv
design/mm_ram.sv
test/tb_mm_ram.sv

//--- run_sim.sh
#!/bin/sh
# compile the mm_ram testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_mm_ram -o tb_mm_ram
./obj_dir/tb_mm_ram 2>&1 | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
